/* hw/mem_cfg.svh */
// data memory configuration: data and address widths, RAM depth and base address
`ifndef MEM_CFG_SVH
`define MEM_CFG_SVH

// width of one RAM location and of the load and store data ports
`define MEM_DATA_W 64

// byte address width as seen by the core
`define MEM_ADDR_W 64

// log2 of the RAM depth in doublewords, 256 doublewords give 2 KiB
`define MEM_INDEX_W 8

// byte address that maps onto RAM location zero
// addresses above the window wrap back into it
`define MEM_BASE 64'h0000_0000_8000_0000

`endif

/* hw/mem_pkg.sv */
// data memory package: access width encoding and the datapath types shared by all blocks
`include "mem_cfg.svh"

package mem_pkg;

    // access size of a load or store, one width per cycle for both ports
    typedef enum logic [1:0] {
        width_byte   = 2'd0,
        width_half   = 2'd1,
        width_word   = 2'd2,
        width_double = 2'd3
    } mem_width_t;

    typedef logic [`MEM_DATA_W-1:0] dword_t;

    // one bit per byte lane of a doubleword, bit 0 is the lowest byte
    typedef logic [7:0] lane_mask_t;

    typedef logic [`MEM_INDEX_W-1:0] mem_index_t;

    // byte position inside a doubleword
    typedef logic [2:0] byte_offset_t;

endpackage

/* hw/access_decode.sv */
// access decoder: rebases a byte address, splits it into index and offset and checks alignment
`include "mem_cfg.svh"

module access_decode
    import mem_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   strobe,
    input  logic [`MEM_ADDR_W-1:0] addr,
    input  mem_width_t             width,
    output logic                   access_en,
    output mem_index_t             index,
    output byte_offset_t           offset,
    output lane_mask_t             lane_mask,
    output logic                   fault
);

    logic [`MEM_ADDR_W-1:0] rebased;
    lane_mask_t             base_mask;
    logic                   aligned;

    // address relative to the start of the RAM window
    assign rebased = addr - `MEM_BASE;

    // bits above the index are dropped, so accesses outside the window wrap
    assign offset = rebased[2:0];
    assign index  = rebased[3 +: `MEM_INDEX_W];

    // lane mask of the access at offset zero, plus the natural alignment test
    always_comb begin
        case (width)
            width_byte: begin
                base_mask = 8'h01;
                aligned   = 1'b1;
            end
            width_half: begin
                base_mask = 8'h03;
                aligned   = (offset[0] == 1'b0);
            end
            width_word: begin
                base_mask = 8'h0f;
                aligned   = (offset[1:0] == 2'b00);
            end
            default: begin
                base_mask = 8'hff;
                aligned   = (offset == 3'b000);
            end
        endcase
    end

    // an aligned access never pushes mask bits past lane 7
    assign lane_mask = base_mask << offset;

    // a misaligned strobe is dropped here and never reaches the RAM
    assign access_en = strobe & aligned;

    // fault pulse follows the offending strobe by one cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            fault <= 1'b0;
        end else begin
            fault <= strobe & ~aligned;
        end
    end

endmodule

/* hw/data_ram.sv */
// data RAM: doubleword-wide storage with byte-lane writes and a registered read port
`include "mem_cfg.svh"

module data_ram
    import mem_pkg::*;
(
    input  logic         clk,
    input  logic         ren,
    input  mem_index_t   rindex,
    output dword_t       rdata,
    input  logic         wen,
    input  mem_index_t   windex,
    input  byte_offset_t woffset,
    input  lane_mask_t   wmask,
    input  dword_t       wdata
);

    localparam int unsigned DEPTH = 2 ** `MEM_INDEX_W;

    dword_t mem [DEPTH];
    dword_t wdata_lanes;

    // store data arrives in the low bits and is moved up to its byte lanes
    assign wdata_lanes = wdata << {woffset, 3'b000};

    // only the lanes selected by the mask are written
    always_ff @(posedge clk) begin
        if (wen) begin
            for (int lane = 0; lane < 8; lane++) begin
                if (wmask[lane]) begin
                    mem[windex][8*lane +: 8] <= wdata_lanes[8*lane +: 8];
                end
            end
        end
    end

    // read samples the array before any write at the same edge lands,
    // so a same-cycle collision returns the old doubleword
    always_ff @(posedge clk) begin
        if (ren) begin
            rdata <= mem[rindex];
        end
    end

endmodule

/* hw/load_align.sv */
// load aligner: extracts the addressed field from the RAM doubleword and zero-extends it
module load_align
    import mem_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  logic         ren,
    input  byte_offset_t offset,
    input  mem_width_t   width,
    input  dword_t       ram_data,
    output dword_t       rdata,
    output logic         rvalid
);

    logic         pending;
    byte_offset_t offset_q;
    mem_width_t   width_q;
    dword_t       shifted;
    dword_t       field;

    // offset and width travel alongside the RAM read
    always_ff @(posedge clk) begin
        if (ren) begin
            offset_q <= offset;
            width_q  <= width;
        end
    end

    // the addressed byte moves down to bit 0
    assign shifted = ram_data >> {offset_q, 3'b000};

    always_comb begin
        case (width_q)
            width_byte:   field = {56'b0, shifted[7:0]};
            width_half:   field = {48'b0, shifted[15:0]};
            width_word:   field = {32'b0, shifted[31:0]};
            default:      field = shifted;
        endcase
    end

    // rdata only changes with rvalid, so it holds the last load between reads
    always_ff @(posedge clk) begin
        if (reset) begin
            pending <= 1'b0;
            rvalid  <= 1'b0;
            rdata   <= '0;
        end else begin
            pending <= ren;
            rvalid  <= pending;
            if (pending) begin
                rdata <= field;
            end
        end
    end

endmodule

/* hw/data_memory.sv */
// data memory top: read and write decoders around the byte-lane RAM and the load aligner
`include "mem_cfg.svh"

module data_memory
    import mem_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   mem_ren,
    input  logic [`MEM_ADDR_W-1:0] mem_raddr,
    input  logic                   mem_wen,
    input  logic [`MEM_ADDR_W-1:0] mem_waddr,
    input  dword_t                 mem_wdata,
    input  mem_width_t             width,
    output dword_t                 mem_rdata,
    output logic                   rvalid,
    output logic                   load_fault,
    output logic                   store_fault
);

    logic         rd_en;
    mem_index_t   rd_index;
    byte_offset_t rd_offset;
    logic         wr_en;
    mem_index_t   wr_index;
    byte_offset_t wr_offset;
    lane_mask_t   wr_mask;
    dword_t       ram_rdata;

    // the read side has no use for a lane mask, the aligner selects the field itself
    access_decode read_decode (
        .clk       (clk),
        .reset     (reset),
        .strobe    (mem_ren),
        .addr      (mem_raddr),
        .width     (width),
        .access_en (rd_en),
        .index     (rd_index),
        .offset    (rd_offset),
        .lane_mask (),
        .fault     (load_fault)
    );

    access_decode write_decode (
        .clk       (clk),
        .reset     (reset),
        .strobe    (mem_wen),
        .addr      (mem_waddr),
        .width     (width),
        .access_en (wr_en),
        .index     (wr_index),
        .offset    (wr_offset),
        .lane_mask (wr_mask),
        .fault     (store_fault)
    );

    data_ram ram (
        .clk     (clk),
        .ren     (rd_en),
        .rindex  (rd_index),
        .rdata   (ram_rdata),
        .wen     (wr_en),
        .windex  (wr_index),
        .woffset (wr_offset),
        .wmask   (wr_mask),
        .wdata   (mem_wdata)
    );

    load_align align (
        .clk      (clk),
        .reset    (reset),
        .ren      (rd_en),
        .offset   (rd_offset),
        .width    (width),
        .ram_data (ram_rdata),
        .rdata    (mem_rdata),
        .rvalid   (rvalid)
    );

endmodule

/* verification/data_memory_tb.sv */
// data memory testbench that checks random loads and stores against a byte-array shadow model
`include "mem_cfg.svh"

module data_memory_tb
    import mem_pkg::*;
();

    localparam int unsigned NUM_DWORDS    = 2 ** `MEM_INDEX_W;
    localparam int unsigned NUM_BYTES     = NUM_DWORDS * 8;
    localparam int unsigned RANDOM_CYCLES = 2000;
    localparam int unsigned RANDOM_SEED   = 59889;
    localparam int          RESET_CYCLES  = 4;
    localparam int          WATCHDOG_TIME = (NUM_DWORDS + RANDOM_CYCLES + 20) * 8;

    // first edge that drives stimulus and the edges that end the fill and random phases
    localparam int START      = RESET_CYCLES - 1;
    localparam int FILL_END   = START + NUM_DWORDS;
    localparam int RANDOM_END = FILL_END + RANDOM_CYCLES;
    localparam int DONE_CYCLE = RANDOM_END + 8;

    // byte position inside the RAM window
    typedef logic [`MEM_INDEX_W+2:0] byte_addr_t;

    logic                   clk = 1'b0;
    logic                   reset = 1'b1;
    logic                   mem_ren = 1'b0;
    logic [`MEM_ADDR_W-1:0] mem_raddr = `MEM_BASE;
    logic                   mem_wen = 1'b0;
    logic [`MEM_ADDR_W-1:0] mem_waddr = `MEM_BASE;
    dword_t                 mem_wdata = '0;
    mem_width_t             width = width_byte;
    dword_t                 mem_rdata;
    logic                   rvalid;
    logic                   load_fault;
    logic                   store_fault;

    int          cycle_count = 0;
    logic        stimulus_done = 1'b0;
    int unsigned data_errors = 0;
    int unsigned protocol_errors = 0;

    logic [7:0] shadow [NUM_BYTES];
    dword_t     expected_q [$];
    dword_t     last_rdata = '0;

    byte_addr_t raddr_pos;
    byte_addr_t waddr_pos;
    logic       load_good;
    logic       load_misaligned;
    logic       store_good;
    logic       store_misaligned;

    data_memory dut (
        .clk         (clk),
        .reset       (reset),
        .mem_ren     (mem_ren),
        .mem_raddr   (mem_raddr),
        .mem_wen     (mem_wen),
        .mem_waddr   (mem_waddr),
        .mem_wdata   (mem_wdata),
        .width       (width),
        .mem_rdata   (mem_rdata),
        .rvalid      (rvalid),
        .load_fault  (load_fault),
        .store_fault (store_fault)
    );

    always #2 clk = ~clk;

    function automatic int unsigned access_bytes(input mem_width_t w);
        case (w)
            width_byte: return 1;
            width_half: return 2;
            width_word: return 4;
            default:    return 8;
        endcase
    endfunction

    // rebase on the RAM start and drop the bits above the window so addresses wrap
    function automatic byte_addr_t window_byte(input logic [`MEM_ADDR_W-1:0] addr);
        logic [`MEM_ADDR_W-1:0] rebased;
        rebased = addr - `MEM_BASE;
        return byte_addr_t'(rebased);
    endfunction

    function automatic logic is_aligned(input byte_addr_t pos, input mem_width_t w);
        return (int'(pos) % access_bytes(w)) == 0;
    endfunction

    function automatic logic [`MEM_ADDR_W-1:0] byte_address(input int unsigned index,
                                                            input int unsigned offset);
        return `MEM_BASE + 64'(index) * 64'd8 + 64'(offset);
    endfunction

    // about one in five offsets for sizes above a byte is skewed off natural alignment
    function automatic int unsigned pick_offset(input mem_width_t w);
        int unsigned size;
        int unsigned base;
        size = access_bytes(w);
        base = $urandom_range(8 / size - 1) * size;
        if (size > 1 && $urandom_range(99) < 20) begin
            return base + $urandom_range(size - 1, 1);
        end
        return base;
    endfunction

    // bytes are assembled little-endian and those above the access size stay zero
    function automatic dword_t read_shadow(input byte_addr_t pos, input mem_width_t w);
        dword_t value;
        value = '0;
        for (int i = 0; i < int'(access_bytes(w)); i++) begin
            value[8*i +: 8] = shadow[pos + byte_addr_t'(i)];
        end
        return value;
    endfunction

    function automatic void write_shadow(input byte_addr_t pos, input mem_width_t w,
                                         input dword_t data);
        for (int i = 0; i < int'(access_bytes(w)); i++) begin
            shadow[pos + byte_addr_t'(i)] = data[8*i +: 8];
        end
    endfunction

    task automatic drive_idle();
        mem_ren <= 1'b0;
        mem_wen <= 1'b0;
        width   <= width_byte;
    endtask

    task automatic drive_fill(input int unsigned index);
        mem_ren   <= 1'b0;
        mem_wen   <= 1'b1;
        mem_waddr <= byte_address(index, 0);
        mem_wdata <= {$urandom, $urandom};
        width     <= width_double;
    endtask

    task automatic drive_random();
        mem_width_t  w;
        int unsigned rd_index;
        int unsigned wr_index;
        w        = mem_width_t'(2'($urandom_range(3)));
        rd_index = $urandom_range(NUM_DWORDS - 1);
        // a quarter of the cycles aim the store at the doubleword being loaded
        if ($urandom_range(99) < 25) begin
            wr_index = rd_index;
        end else begin
            wr_index = $urandom_range(NUM_DWORDS - 1);
        end
        width     <= w;
        mem_ren   <= ($urandom_range(99) < 60);
        mem_raddr <= byte_address(rd_index, pick_offset(w));
        mem_wen   <= ($urandom_range(99) < 60);
        mem_waddr <= byte_address(wr_index, pick_offset(w));
        mem_wdata <= {$urandom, $urandom};
    endtask

    always @(posedge clk) begin
        // this process draws all random stimulus, so its generator takes the seed
        if (cycle_count == 0) begin
            void'($urandom(RANDOM_SEED));
        end
        cycle_count <= cycle_count + 1;
        if (cycle_count == START) begin
            reset <= 1'b0;
        end
        if (cycle_count >= START && cycle_count < FILL_END) begin
            drive_fill(cycle_count - START);
        end else if (cycle_count >= FILL_END && cycle_count < RANDOM_END) begin
            drive_random();
        end else begin
            drive_idle();
        end
        if (cycle_count == DONE_CYCLE) begin
            stimulus_done <= 1'b1;
        end
    end

    assign raddr_pos        = window_byte(mem_raddr);
    assign waddr_pos        = window_byte(mem_waddr);
    assign load_good        = mem_ren && is_aligned(raddr_pos, width);
    assign load_misaligned  = mem_ren && !is_aligned(raddr_pos, width);
    assign store_good       = mem_wen && is_aligned(waddr_pos, width);
    assign store_misaligned = mem_wen && !is_aligned(waddr_pos, width);

    load_fault_timing: assert property (
        @(posedge clk) disable iff (reset) load_fault == $past(load_misaligned)
    ) else begin
        protocol_errors = protocol_errors + 1;
        $display("load_fault does not pulse one cycle after a misaligned load");
    end

    store_fault_timing: assert property (
        @(posedge clk) disable iff (reset) store_fault == $past(store_misaligned)
    ) else begin
        protocol_errors = protocol_errors + 1;
        $display("store_fault does not pulse one cycle after a misaligned store");
    end

    rvalid_timing: assert property (
        @(posedge clk) disable iff (reset) rvalid == $past(load_good, 2)
    ) else begin
        protocol_errors = protocol_errors + 1;
        $display("rvalid pulse does not line up with an aligned load");
    end

    // outputs are checked as they stand before this edge and this edge's accesses are modeled after
    always @(posedge clk) begin
        dword_t expected;
        if (reset) begin
            last_rdata = '0;
            expected_q.delete();
        end else begin
            if (rvalid) begin
                if (expected_q.size() == 0) begin
                    data_errors = data_errors + 1;
                    $display("rvalid pulsed although no load was outstanding");
                end else begin
                    expected = expected_q.pop_front();
                    assert (mem_rdata == expected) else begin
                        data_errors = data_errors + 1;
                        $display("Mismatch mem_rdata expected %h got %h", expected, mem_rdata);
                    end
                end
                last_rdata = mem_rdata;
            end else begin
                assert (mem_rdata == last_rdata) else begin
                    data_errors = data_errors + 1;
                    $display("Mismatch mem_rdata expected %h got %h", last_rdata, mem_rdata);
                end
            end
            // the shadow is read before the store of the same edge lands
            if (load_good) begin
                expected_q.push_back(read_shadow(raddr_pos, width));
            end
            if (store_good) begin
                write_shadow(waddr_pos, width, mem_wdata);
            end
        end
    end

    initial begin
        wait (stimulus_done == 1'b1);
        $display("summary: %0d data errors, %0d protocol errors", data_errors, protocol_errors);
        if (data_errors + protocol_errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin
        #WATCHDOG_TIME;
        $display("watchdog expired before the stimulus finished");
        $display("summary: %0d data errors, %0d protocol errors", data_errors, protocol_errors);
        $display("TEST FAILED");
        $finish;
    end

endmodule

/* compile.f */
+incdir+hw
hw/mem_pkg.sv
hw/access_decode.sv
hw/data_ram.sv
hw/load_align.sv
hw/data_memory.sv
verification/data_memory_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds the data memory testbench with Verilator, runs it and scans the log

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
    echo "cannot enter the project root"
    exit 1
fi

TOP=data_memory_tb
BUILD_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --timing --assert -f compile.f --top-module "$TOP" \
    --Mdir "$BUILD_DIR" -o "$TOP"
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$BUILD_DIR/$TOP" > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q "TEST FAILED" "$LOG_FILE"; then
    echo "failure reported in $LOG_FILE"
    exit 1
fi

echo "no failure reported in $LOG_FILE"
exit 0
